// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mrpt_mem_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/mrpt_mem_tb.sv ====
`default_nettype none

module mrpt_mem_tb import mrpt_mem_pkg::*; ();

  localparam int lat        = 3 + sram_delay;
  localparam int max_cycles = 4000;

  logic                                clk;
  logic                                arst_n;
  mem_mode_e                           mode;
  logic                                write;
  logic [bits_addr-1:0]                wr_addr;
  logic [data_width-1:0]               wr_data;
  logic [num_banks-1:0]                read;
  logic [num_banks-1:0][bits_addr-1:0] rd_addr;
  wire                                 ready;
  wire [num_banks-1:0]                 rd_vld;
  wire [num_banks-1:0][data_width-1:0] rd_data;
  wire [num_banks-1:0]                 sram_write;
  wire [num_banks-1:0][bits_srow-1:0]  sram_wr_row;
  wire [num_banks-1:0][phy_width-1:0]  sram_bw;
  wire [num_banks-1:0][phy_width-1:0]  sram_din;
  wire [num_banks-1:0]                 sram_read;
  wire [num_banks-1:0][bits_srow-1:0]  sram_rd_row;
  wire [num_banks-1:0][phy_width-1:0]  sram_dout;

  logic [data_width-1:0] ref_mem [num_banks*vrow_per_bank];
  mem_mode_e             ref_mode;
  logic                  ref_ready;
  logic                  exp_vld  [num_banks][lat+1];
  logic [data_width-1:0] exp_data [num_banks][lat+1];
  int                    sweep_writes [num_banks];
  int                    rst_cycles;
  logic                  count_writes = 1'b0;
  int                    errors = 0;
  int                    reads_checked = 0;
  int                    cycles;
  string                 test_name = "reset";

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  mrpt_mem_top #(.data_width_p (data_width), .sram_delay_p (sram_delay)) i_dut (
    .clk (clk), .arst_n (arst_n), .mode (mode), .ready (ready),
    .write (write), .wr_addr (wr_addr), .wr_data (wr_data),
    .read (read), .rd_addr (rd_addr), .rd_vld (rd_vld), .rd_data (rd_data),
    .sram_write (sram_write), .sram_wr_row (sram_wr_row), .sram_bw (sram_bw),
    .sram_din (sram_din), .sram_read (sram_read), .sram_rd_row (sram_rd_row),
    .sram_dout (sram_dout)
  );

  for (genvar b = 0; b < num_banks; b++) begin : g_sram
    sram_model i_sram (
      .clk (clk), .write (sram_write[b]), .wr_row (sram_wr_row[b]), .bw (sram_bw[b]),
      .din (sram_din[b]), .read (sram_read[b]), .rd_row (sram_rd_row[b]),
      .dout (sram_dout[b])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic int addr_span();
    return (ref_mode == mode_replicated) ? vrow_per_bank : num_banks * vrow_per_bank;
  endfunction

  // banked mode serves port 0 only.
  function automatic logic read_hit(int p);
    return (ref_mode == mode_replicated || p == 0) && read[p] &&
           int'(rd_addr[p]) < addr_span();
  endfunction

  // the memory accepts commands once one cycle per SRAM row has passed.
  assign ref_ready = (rst_cycles >= num_srow);

  // memory contents are cleared by the sweep, so the model starts from zero.
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ref_mode   <= mode;
      rst_cycles <= 0;
      for (int a = 0; a < num_banks * vrow_per_bank; a++) begin
        ref_mem[a] <= '0;
      end
      for (int p = 0; p < num_banks; p++) begin
        for (int k = 0; k <= lat; k++) begin
          exp_vld[p][k]  <= 1'b0;
          exp_data[p][k] <= '0;
        end
      end
    end else begin
      if (rst_cycles < max_cycles) begin
        rst_cycles <= rst_cycles + 1;
      end
      for (int p = 0; p < num_banks; p++) begin
        exp_vld[p][0]  <= ref_ready && read_hit(p);
        exp_data[p][0] <= read_hit(p) ? ref_mem[rd_addr[p]] : '0;
        for (int k = 1; k <= lat; k++) begin
          exp_vld[p][k]  <= exp_vld[p][k-1];
          exp_data[p][k] <= exp_data[p][k-1];
        end
      end
      if (ref_ready && write && int'(wr_addr) < addr_span()) begin
        ref_mem[wr_addr] <= wr_data;
      end
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < num_banks; b++) begin
      if (!count_writes) begin
        sweep_writes[b] <= 0;
      end else if (sram_write[b]) begin
        sweep_writes[b] <= sweep_writes[b] + 1;
      end
    end
  end

  always @(negedge clk) begin
    for (int p = 0; p < num_banks; p++) begin
      if (arst_n && exp_vld[p][lat]) begin
        reads_checked++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assert property (@(negedge clk) disable iff (!arst_n) ready == ref_ready)
    else begin
      errors++;
      $display("FAILED %s ready after %0d cycles expected %0b actual %0b",
               test_name, rst_cycles, ref_ready, ready);
    end

  for (genvar i = 0; i < num_banks; i++) begin : g_check
    assert property (@(negedge clk) disable iff (!arst_n) rd_vld[i] == exp_vld[i][lat])
      else begin
        errors++;
        $display("FAILED %s port %0d rd_vld expected %0b actual %0b",
                 test_name, i, exp_vld[i][lat], rd_vld[i]);
      end
    assert property (@(negedge clk) disable iff (!arst_n)
                     !exp_vld[i][lat] || rd_data[i] == exp_data[i][lat])
      else begin
        errors++;
        $display("FAILED %s port %0d rd_data expected %h actual %h",
                 test_name, i, exp_data[i][lat], rd_data[i]);
      end
    // the last sweep writes reach the pins one cycle after ready rises.
    assert property (@(negedge clk) disable iff (!arst_n)
                     !(sram_write[i] && rst_cycles <= num_srow + 1) ||
                     (sram_bw[i] == '1 && sram_din[i] == '0))
      else begin
        errors++;
        $display("FAILED %s bank %0d sweep bw/din expected %h/%h actual %h/%h",
                 test_name, i, {phy_width{1'b1}}, {phy_width{1'b0}},
                 sram_bw[i], sram_din[i]);
      end
    assert property (@(negedge clk) disable iff (!arst_n)
                     !(sram_read[i] && rst_cycles <= num_srow + 1))
      else begin
        errors++;
        $display("FAILED %s bank %0d sram_read expected 0 actual 1", test_name, i);
      end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic clear_inputs();
    write   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    read    = '0;
    rd_addr = '0;
  endtask

  task automatic drain_reads();
    @(negedge clk);
    clear_inputs();
    repeat (lat + 2) @(negedge clk);
  endtask

  task automatic apply_reset(mem_mode_e m);
    @(negedge clk);
    clear_inputs();
    mode   = m;
    arst_n = 1'b0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    while (!ready) begin
      @(negedge clk);
    end
  endtask

  task automatic sweep_after_reset();
    test_name    = "sweep";
    count_writes = 1'b1;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    // commands offered during the sweep must be ignored.
    write   = 1'b1;
    wr_data = '1;
    read    = '1;
    while (!ready) begin
      @(negedge clk);
    end
    clear_inputs();
    repeat (4) @(negedge clk);
    for (int b = 0; b < num_banks; b++) begin
      assert (sweep_writes[b] == num_srow)
        else begin
          errors++;
          $display("FAILED %s bank %0d write count expected %0d actual %0d",
                   test_name, b, num_srow, sweep_writes[b]);
        end
    end
    count_writes = 1'b0;
  endtask

  task automatic read_every_word(string name, int span);
    test_name = name;
    for (int a = 0; a < span; a++) begin
      @(negedge clk);
      clear_inputs();
      read = '1;
      for (int p = 0; p < num_banks; p++) begin
        rd_addr[p] = bits_addr'((a + 13 * p) % span);
      end
    end
    drain_reads();
  endtask

  task automatic write_every_word(string name, int span);
    test_name = name;
    for (int a = 0; a < span; a++) begin
      @(negedge clk);
      clear_inputs();
      write   = 1'b1;
      wr_addr = bits_addr'(a);
      wr_data = data_width'($urandom);
    end
    drain_reads();
  endtask

  // spans beyond the mapped range also exercise ignored addresses.
  task automatic random_traffic(string name, int n, int span);
    test_name = name;
    for (int c = 0; c < n; c++) begin
      @(negedge clk);
      write   = ($urandom % 2) == 1;
      wr_addr = bits_addr'($urandom % span);
      wr_data = data_width'($urandom);
      read    = num_banks'($urandom);
      for (int p = 0; p < num_banks; p++) begin
        rd_addr[p] = bits_addr'($urandom % span);
      end
    end
    drain_reads();
  endtask

  task automatic lane_isolation(int row);
    int base;
    base      = row * num_wrds;
    test_name = "lane_isolation";
    for (int l = 0; l < num_wrds; l++) begin
      @(negedge clk);
      clear_inputs();
      write   = 1'b1;
      wr_addr = bits_addr'(base + l);
      wr_data = data_width'($urandom);
      @(negedge clk);
      clear_inputs();
      read = '1;
      for (int p = 0; p < num_banks; p++) begin
        rd_addr[p] = bits_addr'(base - 1 + p);
      end
    end
    drain_reads();
  endtask

  task automatic write_read_collision(int addr);
    test_name = "collision";
    @(negedge clk);
    clear_inputs();
    write      = 1'b1;
    wr_addr    = bits_addr'(addr);
    wr_data    = ~ref_mem[addr];
    read[0]    = 1'b1;
    rd_addr[0] = bits_addr'(addr);
    @(negedge clk);
    clear_inputs();
    read[1:0]  = 2'b11;
    rd_addr[0] = bits_addr'(addr);
    rd_addr[1] = bits_addr'(addr);
    drain_reads();
  endtask

  initial begin
    void'($urandom(32'h820f));
    arst_n = 1'b0;
    mode   = mode_replicated;
    clear_inputs();
    sweep_after_reset();
    read_every_word("replicated_zero", vrow_per_bank);
    random_traffic("replicated_random", 600, vrow_per_bank + 16);
    lane_isolation(9);
    write_read_collision(17);
    apply_reset(mode_banked);
    read_every_word("banked_zero", num_banks * vrow_per_bank);
    write_every_word("banked_fill", num_banks * vrow_per_bank);
    read_every_word("banked_readback", num_banks * vrow_per_bank);
    random_traffic("banked_random", 300, 400);
    $display("%0d reads checked, %0d errors", reads_checked, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("timeout: the run did not finish within %0d cycles", max_cycles);
    $display("%0d reads checked, %0d errors", reads_checked, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/sram_model.sv ====
`default_nettype none

module sram_model import mrpt_mem_pkg::*; #(
  parameter int width_p = phy_width,
  parameter int delay_p = sram_delay
) (
  input  wire                 clk,
  input  wire                 write,
  input  wire [bits_srow-1:0] wr_row,
  input  wire [width_p-1:0]   bw,
  input  wire [width_p-1:0]   din,
  input  wire                 read,
  input  wire [bits_srow-1:0] rd_row,
  output wire [width_p-1:0]   dout
);

  logic [width_p-1:0] mem  [num_srow];
  logic [width_p-1:0] pipe [delay_p+1];

  // rows start with a nonzero pattern so that the clearing sweep is visible.
  initial begin
    for (int r = 0; r < num_srow; r++) begin
      mem[r] = ~width_p'(r);
    end
  end

  // the row is captured at the read edge and leaves through delay_p more stages.
  // a read and a write to the same row at one edge return the old row.
  always @(posedge clk) begin
    if (read) begin
      pipe[0] <= mem[rd_row];
    end
    for (int i = 1; i <= delay_p; i++) begin
      pipe[i] <= pipe[i-1];
    end
    if (write) begin
      mem[wr_row] <= (mem[wr_row] & ~bw) | (din & bw);
    end
  end

  assign dout = pipe[delay_p];

endmodule

`default_nettype wire

// ==== build.f ====
rtl/mrpt_mem_pkg.sv
rtl/tag_delay.sv
rtl/row_align.sv
rtl/port_mapper.sv
rtl/read_return.sv
rtl/mrpt_mem_top.sv
bench/sram_model.sv
bench/mrpt_mem_tb.sv

// ==== rtl/mrpt_mem_pkg.sv ====
`default_nettype none

package mrpt_mem_pkg;

  // word and bank geometry.
  localparam int data_width    = 16;
  localparam int num_banks     = 5;
  localparam int num_srow      = 16;
  localparam int num_wrds      = 4;
  localparam int vrow_per_bank = num_srow * num_wrds;

  // index widths derived from the geometry.
  localparam int bits_srow = $clog2(num_srow);
  localparam int bits_wrds = $clog2(num_wrds);
  localparam int bits_vrow = $clog2(vrow_per_bank);
  localparam int bits_bank = $clog2(num_banks);
  localparam int bits_addr = $clog2(num_banks * vrow_per_bank);

  // one SRAM row holds num_wrds words side by side.
  localparam int phy_width = num_wrds * data_width;

  localparam int sram_delay = 2;

  typedef enum logic {
    mode_replicated = 1'b0,
    mode_banked     = 1'b1
  } mem_mode_e;

endpackage

`default_nettype wire

// ==== rtl/mrpt_mem_top.sv ====
`default_nettype none

module mrpt_mem_top import mrpt_mem_pkg::*; #(
  parameter int data_width_p = data_width,
  parameter int sram_delay_p = sram_delay
) (
  input  wire                                            clk,
  input  wire                                            arst_n,
  input  wire mem_mode_e                                 mode,
  output wire                                            ready,
  input  wire                                            write,
  input  wire [bits_addr-1:0]                            wr_addr,
  input  wire [data_width_p-1:0]                         wr_data,
  input  wire [num_banks-1:0]                            read,
  input  wire [num_banks-1:0][bits_addr-1:0]             rd_addr,
  output wire [num_banks-1:0]                            rd_vld,
  output wire [num_banks-1:0][data_width_p-1:0]          rd_data,
  output wire [num_banks-1:0]                            sram_write,
  output wire [num_banks-1:0][bits_srow-1:0]             sram_wr_row,
  output wire [num_banks-1:0][num_wrds*data_width_p-1:0] sram_bw,
  output wire [num_banks-1:0][num_wrds*data_width_p-1:0] sram_din,
  output wire [num_banks-1:0]                            sram_read,
  output wire [num_banks-1:0][bits_srow-1:0]             sram_rd_row,
  input  wire [num_banks-1:0][num_wrds*data_width_p-1:0] sram_dout
);

  wire                                   bank_clear;
  wire [num_banks-1:0]                   bank_write;
  wire [num_banks-1:0][bits_vrow-1:0]    bank_wr_vrow;
  wire [num_banks-1:0][data_width_p-1:0] bank_wr_data;
  wire [num_banks-1:0]                   bank_read;
  wire [num_banks-1:0][bits_vrow-1:0]    bank_rd_vrow;
  wire [num_banks-1:0]                   rd_req;
  wire [num_banks-1:0][bits_bank-1:0]    rd_bank;
  wire [num_banks-1:0][bits_wrds-1:0]    rd_lane;

  port_mapper #(.data_width_p (data_width_p)) i_port_mapper (
    .clk          (clk),
    .arst_n       (arst_n),
    .mode         (mode),
    .write        (write),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .read         (read),
    .rd_addr      (rd_addr),
    .ready        (ready),
    .bank_clear   (bank_clear),
    .bank_write   (bank_write),
    .bank_wr_vrow (bank_wr_vrow),
    .bank_wr_data (bank_wr_data),
    .bank_read    (bank_read),
    .bank_rd_vrow (bank_rd_vrow),
    .rd_req       (rd_req),
    .rd_bank      (rd_bank)
  );

  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    row_align #(.data_width_p (data_width_p)) i_row_align (
      .clk         (clk),
      .arst_n      (arst_n),
      .clear       (bank_clear),
      .write       (bank_write[b]),
      .wr_vrow     (bank_wr_vrow[b]),
      .wr_data     (bank_wr_data[b]),
      .read        (bank_read[b]),
      .rd_vrow     (bank_rd_vrow[b]),
      .sram_write  (sram_write[b]),
      .sram_wr_row (sram_wr_row[b]),
      .sram_bw     (sram_bw[b]),
      .sram_din    (sram_din[b]),
      .sram_read   (sram_read[b]),
      .sram_rd_row (sram_rd_row[b]),
      .rd_lane     (rd_lane[b])
    );
  end

  read_return #(
    .data_width_p (data_width_p),
    .sram_delay_p (sram_delay_p)
  ) i_read_return (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_req    (rd_req),
    .rd_bank   (rd_bank),
    .rd_lane   (rd_lane),
    .sram_read (sram_read),
    .sram_dout (sram_dout),
    .rd_vld    (rd_vld),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

// ==== rtl/port_mapper.sv ====
`default_nettype none

module port_mapper import mrpt_mem_pkg::*; #(
  parameter int data_width_p = data_width
) (
  input  wire                                         clk,
  input  wire                                         arst_n,
  input  wire mem_mode_e                              mode,
  input  wire                                         write,
  input  wire [bits_addr-1:0]                         wr_addr,
  input  wire [data_width_p-1:0]                      wr_data,
  input  wire [num_banks-1:0]                         read,
  input  wire [num_banks-1:0][bits_addr-1:0]          rd_addr,
  output logic                                        ready,
  output logic                                        bank_clear,
  output logic [num_banks-1:0]                        bank_write,
  output logic [num_banks-1:0][bits_vrow-1:0]         bank_wr_vrow,
  output logic [num_banks-1:0][data_width_p-1:0]      bank_wr_data,
  output logic [num_banks-1:0]                        bank_read,
  output logic [num_banks-1:0][bits_vrow-1:0]         bank_rd_vrow,
  output logic [num_banks-1:0]                        rd_req,
  output logic [num_banks-1:0][bits_bank-1:0]         rd_bank
);

  logic [bits_srow-1:0]                sweep_row;
  mem_mode_e                           mode_q;
  logic [bits_bank-1:0]                wr_bank;
  logic [bits_bank-1:0]                rd_bank0;
  logic [num_banks-1:0]                write_d;
  logic [num_banks-1:0]                read_d;
  logic [num_banks-1:0]                req_d;
  logic [num_banks-1:0][bits_bank-1:0] bank_d;

  assign wr_bank  = wr_addr[bits_addr-1:bits_vrow];
  assign rd_bank0 = rd_addr[0][bits_addr-1:bits_vrow];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mode mapping of user commands onto the banks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    write_d = '0;
    read_d  = '0;
    req_d   = '0;
    for (int b = 0; b < num_banks; b++) begin
      bank_d[b] = bits_bank'(b);
      if (ready && mode_q == mode_replicated) begin
        write_d[b] = write && (wr_addr < bits_addr'(vrow_per_bank));
        read_d[b]  = read[b] && (rd_addr[b] < bits_addr'(vrow_per_bank));
        req_d[b]   = read[b] && (rd_addr[b] < bits_addr'(vrow_per_bank));
      end else if (ready) begin
        write_d[b] = write && (wr_bank == bits_bank'(b));
        read_d[b]  = read[0] && (rd_bank0 == bits_bank'(b));
      end
    end
    // banked mode serves port 0 only; banks 5 to 7 match nothing.
    if (ready && mode_q == mode_banked) begin
      req_d[0]  = read[0] && (rd_bank0 < bits_bank'(num_banks));
      bank_d[0] = rd_bank0;
    end
  end

  // the sweep owns every bank until ready rises.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready      <= 1'b0;
      sweep_row  <= '0;
      mode_q     <= mode_replicated;
      bank_clear <= 1'b0;
      bank_write <= '0;
      bank_read  <= '0;
      rd_req     <= '0;
    end else begin
      bank_clear <= !ready;
      bank_write <= ready ? write_d : '1;
      bank_read  <= read_d;
      rd_req     <= req_d;
      if (!ready) begin
        sweep_row <= sweep_row + 1'b1;
        if (sweep_row == '0) begin
          mode_q <= mode;
        end
        if (sweep_row == bits_srow'(num_srow - 1)) begin
          ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < num_banks; b++) begin
      bank_wr_vrow[b] <= ready ? wr_addr[bits_vrow-1:0] : {sweep_row, {bits_wrds{1'b0}}};
      bank_wr_data[b] <= ready ? wr_data : '0;
      bank_rd_vrow[b] <= (mode_q == mode_banked) ? rd_addr[0][bits_vrow-1:0]
                                                 : rd_addr[b][bits_vrow-1:0];
      rd_bank[b]      <= bank_d[b];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/read_return.sv ====
`default_nettype none

module read_return import mrpt_mem_pkg::*; #(
  parameter int data_width_p = data_width,
  parameter int sram_delay_p = sram_delay
) (
  input  wire                                          clk,
  input  wire                                          arst_n,
  input  wire [num_banks-1:0]                          rd_req,
  input  wire [num_banks-1:0][bits_bank-1:0]           rd_bank,
  input  wire [num_banks-1:0][bits_wrds-1:0]           rd_lane,
  input  wire [num_banks-1:0]                          sram_read,
  input  wire [num_banks-1:0][num_wrds*data_width_p-1:0] sram_dout,
  output logic [num_banks-1:0]                         rd_vld,
  output logic [num_banks-1:0][data_width_p-1:0]       rd_data
);

  logic [num_banks-1:0]                   lane_vld;
  logic [num_banks-1:0][bits_wrds-1:0]    lane_tag;
  logic [num_banks-1:0]                   port_vld;
  logic [num_banks-1:0][bits_bank-1:0]    port_bank;
  logic [num_banks-1:0]                   sel_vld;
  logic [num_banks-1:0][data_width_p-1:0] sel_data;

  // lane tags leave with the SRAM command, port tags one stage earlier.
  for (genvar i = 0; i < num_banks; i++) begin : g_tags
    tag_delay #(
      .tag_t (logic [bits_wrds-1:0]),
      .depth (sram_delay_p + 1)
    ) i_lane_delay (
      .clk     (clk),
      .arst_n  (arst_n),
      .vld_in  (sram_read[i]),
      .tag_in  (rd_lane[i]),
      .vld_out (lane_vld[i]),
      .tag_out (lane_tag[i])
    );

    tag_delay #(
      .tag_t (logic [bits_bank-1:0]),
      .depth (sram_delay_p + 2)
    ) i_port_delay (
      .clk     (clk),
      .arst_n  (arst_n),
      .vld_in  (rd_req[i]),
      .tag_in  (rd_bank[i]),
      .vld_out (port_vld[i]),
      .tag_out (port_bank[i])
    );
  end

  always_comb begin
    sel_vld  = '0;
    sel_data = '0;
    for (int p = 0; p < num_banks; p++) begin
      for (int b = 0; b < num_banks; b++) begin
        if (port_bank[p] == bits_bank'(b)) begin
          sel_vld[p]  = port_vld[p] && lane_vld[b];
          sel_data[p] = sram_dout[b][lane_tag[b]*data_width_p +: data_width_p];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= sel_vld;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= sel_data;
  end

endmodule

`default_nettype wire

// ==== rtl/row_align.sv ====
`default_nettype none

module row_align import mrpt_mem_pkg::*; #(
  parameter int data_width_p = data_width
) (
  input  wire                            clk,
  input  wire                            arst_n,
  input  wire                            clear,
  input  wire                            write,
  input  wire [bits_vrow-1:0]            wr_vrow,
  input  wire [data_width_p-1:0]         wr_data,
  input  wire                            read,
  input  wire [bits_vrow-1:0]            rd_vrow,
  output logic                           sram_write,
  output logic [bits_srow-1:0]           sram_wr_row,
  output logic [num_wrds*data_width_p-1:0] sram_bw,
  output logic [num_wrds*data_width_p-1:0] sram_din,
  output logic                           sram_read,
  output logic [bits_srow-1:0]           sram_rd_row,
  output logic [bits_wrds-1:0]           rd_lane
);

  localparam int phy_w = num_wrds * data_width_p;

  logic [bits_wrds-1:0] wr_lane;
  logic [phy_w-1:0]     lane_mask;

  // low bits of the virtual row pick the word lane, the rest the SRAM row.
  assign wr_lane   = wr_vrow[bits_wrds-1:0];
  assign lane_mask = phy_w'({data_width_p{1'b1}}) << (wr_lane * data_width_p);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sram_write <= 1'b0;
      sram_read  <= 1'b0;
    end else begin
      sram_write <= write;
      sram_read  <= read;
    end
  end

  // the word is copied to every lane and the mask keeps only its own.
  // the clearing sweep writes whole rows.
  always_ff @(posedge clk) begin
    sram_wr_row <= wr_vrow[bits_vrow-1:bits_wrds];
    sram_bw     <= clear ? '1 : lane_mask;
    sram_din    <= {num_wrds{wr_data}};
    sram_rd_row <= rd_vrow[bits_vrow-1:bits_wrds];
    rd_lane     <= rd_vrow[bits_wrds-1:0];
  end

endmodule

`default_nettype wire

// ==== rtl/tag_delay.sv ====
`default_nettype none

module tag_delay #(
  parameter type tag_t = logic,
  parameter int  depth = 1
) (
  input  wire       clk,
  input  wire       arst_n,
  input  wire       vld_in,
  input  wire tag_t tag_in,
  output logic      vld_out,
  output tag_t      tag_out
);

  logic [depth-1:0] vld_q;
  tag_t             tag_q [depth];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
      for (int i = 0; i < depth; i++) begin
        tag_q[i] <= tag_t'(0);
      end
    end else begin
      vld_q[0] <= vld_in;
      tag_q[0] <= tag_in;
      for (int i = 1; i < depth; i++) begin
        vld_q[i] <= vld_q[i-1];
        tag_q[i] <= tag_q[i-1];
      end
    end
  end

  assign vld_out = vld_q[depth-1];
  assign tag_out = tag_q[depth-1];

endmodule

`default_nettype wire
